/* list.f */
src/coreDefs.sv
src/fetchUnit.sv
src/decoder.sv
src/regFile.sv
src/bypassUnit.sv
src/alu.sv
src/mipsCore.sv
verification/coreTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module coreTb -o coreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

/* src/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import coreDefs::*; (
    input  aluOpT      aluOp,
    input  wordT       operandA,
    input  wordT       operandB,
    input  logic [4:0] shamt,
    input  logic       useShamt,
    output wordT       result
);

    logic [4:0] shiftAmt;

    assign shiftAmt = useShamt ? shamt : operandA[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:  result = operandA + operandB;  // wraps, no trap
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluNor:  result = ~(operandA | operandB);
            aluSlt:  result = wordT'($signed(operandA) < $signed(operandB));
            aluSltu: result = wordT'(operandA < operandB);
            aluSll:  result = operandB << shiftAmt;
            aluSrl:  result = operandB >> shiftAmt;
            aluSra:  result = wordT'($signed(operandB) >>> shiftAmt);
            aluLui:  result = {operandB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/bypassUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module bypassUnit import coreDefs::*; (
    input  regAddrT srcA,
    input  regAddrT srcB,
    input  regAddrT exDest,
    input  logic    exWrite,
    input  regAddrT wbDest,
    input  logic    wbWrite,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB
);

    // youngest producer wins
    function automatic fwdSelT pickSource(regAddrT src);
        fwdSelT sel;
        if (exWrite && (exDest == src)) begin
            sel = fwdExResult;
        end else if (wbWrite && (wbDest == src)) begin
            sel = fwdWbResult;
        end else begin
            sel = fwdRegFile;
        end
        return sel;
    endfunction

    assign fwdA = pickSource(srcA);
    assign fwdB = pickSource(srcB);

endmodule

`default_nettype wire

/* src/coreDefs.sv */
`default_nettype none

package coreDefs;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    localparam wordT resetPc = 32'hBFC0_0000;

    // opcode field [31:26]
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0A;
    localparam logic [5:0] opSltiu   = 6'h0B;
    localparam logic [5:0] opAndi    = 6'h0C;
    localparam logic [5:0] opOri     = 6'h0D;
    localparam logic [5:0] opXori    = 6'h0E;
    localparam logic [5:0] opLui     = 6'h0F;

    // funct field [5:0] of special
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2A;
    localparam logic [5:0] fnSltu = 6'h2B;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    typedef enum logic [1:0] {immZero, immSign, immUpper} immKindT;

    typedef enum logic [2:0] {brNone, brBeq, brBne, brJump, brJumpReg} branchT;

    typedef enum logic [1:0] {fwdRegFile, fwdExResult, fwdWbResult} fwdSelT;

endpackage

`default_nettype wire

/* src/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder import coreDefs::*; (
    input  wordT    instr,
    output aluOpT   aluOp,
    output logic    useImm,
    output wordT    immValue,
    output logic    useShamt,
    output regAddrT destReg,
    output logic    regWrite,
    output branchT  branchKind
);

    logic [5:0] opcode;
    logic [5:0] funct;
    immKindT    immKind;
    logic       destIsRt;
    logic       writes;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        aluOp      = aluAdd;
        useImm     = 1'b0;
        immKind    = immSign;   // branch offsets too
        useShamt   = 1'b0;
        destIsRt   = 1'b0;
        writes     = 1'b0;
        branchKind = brNone;
        case (opcode)
            opSpecial: begin
                writes = 1'b1;
                case (funct)
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnSra:   aluOp = aluSra;
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    fnJr: begin
                        writes     = 1'b0;
                        branchKind = brJumpReg;
                    end
                    default: writes = 1'b0;
                endcase
                useShamt = (funct == fnSll) || (funct == fnSrl) || (funct == fnSra);
            end
            opJ:   branchKind = brJump;
            opBeq: branchKind = brBeq;
            opBne: branchKind = brBne;
            opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                useImm   = 1'b1;
                destIsRt = 1'b1;
                writes   = 1'b1;
                case (opcode)
                    opSlti:  aluOp = aluSlt;
                    opSltiu: aluOp = aluSltu;   // still sign extended
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opXori:  aluOp = aluXor;
                    opLui:   aluOp = aluLui;
                    default: aluOp = aluAdd;
                endcase
                if (opcode == opLui) begin
                    immKind = immUpper;
                end else if (opcode inside {opAndi, opOri, opXori}) begin
                    immKind = immZero;
                end
            end
            default: ;  // unknown encodings neither write nor redirect
        endcase
    end

    always_comb begin
        case (immKind)
            immSign: immValue = {{16{instr[15]}}, instr[15:0]};
            default: immValue = {16'h0000, instr[15:0]};  // lui is lifted in the alu
        endcase
    end

    assign destReg  = destIsRt ? instr[20:16] : instr[15:11];
    assign regWrite = writes && (destReg != '0);

endmodule

`default_nettype wire

/* src/fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import coreDefs::*; (
    input  logic        clk,
    input  logic        rst,
    input  branchT      branchKind,
    input  logic        operandsEqual,
    input  wordT        branchOffset,
    input  logic [25:0] jumpIndex,
    input  wordT        regTarget,
    output wordT        instAddr,
    output wordT        fetchPc
);

    wordT nextPc;
    wordT branchTarget;
    wordT jumpTarget;

    // fetchPc is the delay slot while the branch sits in decode
    assign branchTarget = fetchPc + {branchOffset[29:0], 2'b00};
    assign jumpTarget   = {fetchPc[31:28], jumpIndex, 2'b00};

    always_comb begin
        nextPc = fetchPc + 32'd4;
        case (branchKind)
            brBeq:     if (operandsEqual) nextPc = branchTarget;
            brBne:     if (!operandsEqual) nextPc = branchTarget;
            brJump:    nextPc = jumpTarget;
            brJumpReg: nextPc = regTarget;
            default:   ;
        endcase
    end

    assign instAddr = rst ? resetPc : nextPc;  // reset vector

    // word on instData next cycle belongs to this address
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPc <= resetPc;
        end else begin
            fetchPc <= instAddr;
        end
    end

endmodule

`default_nettype wire

/* src/mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore import coreDefs::*; (
    input  logic       clk,
    input  logic       rst,
    input  wordT       instData,
    output wordT       instAddr,
    output wordT       debugWbPc,
    output logic [3:0] debugWbRfWen,
    output regAddrT    debugWbRfWnum,
    output wordT       debugWbRfWdata
);

    // fetch
    wordT    fetchPc;
    wordT    ifIdPc;
    wordT    ifIdInstr;
    // decode
    aluOpT   decAluOp;
    logic    decUseImm;
    wordT    decImm;
    logic    decUseShamt;
    regAddrT decDest;
    logic    decWrite;
    branchT  decBranch;
    wordT    rfDataA;
    wordT    rfDataB;
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    wordT    opA;
    wordT    opB;
    // execute
    wordT    idExPc;
    wordT    idExA;
    wordT    idExB;
    aluOpT   idExAluOp;
    logic    [4:0] idExShamt;
    logic    idExUseShamt;
    regAddrT idExDest;
    logic    idExWrite;
    wordT    exResult;
    // writeback
    wordT    wbPc;
    wordT    wbData;
    regAddrT wbDest;
    logic    wbWrite;

    function automatic wordT pickOperand(fwdSelT sel, wordT rfValue, wordT exValue,
                                         wordT wbValue);
        case (sel)
            fwdExResult: return exValue;
            fwdWbResult: return wbValue;
            default:     return rfValue;
        endcase
    endfunction

    fetchUnit uFetch (
        .clk(clk), .rst(rst), .branchKind(decBranch), .operandsEqual(opA == opB),
        .branchOffset(decImm), .jumpIndex(ifIdInstr[25:0]), .regTarget(opA),
        .instAddr(instAddr), .fetchPc(fetchPc)
    );

    // IF/ID, reset to an all-zero word (sll r0, a nop)
    always_ff @(posedge clk) begin
        if (rst) begin
            ifIdInstr <= '0;
        end else begin
            ifIdInstr <= instData;
        end
    end

    always_ff @(posedge clk) begin
        ifIdPc <= fetchPc;
    end

    decoder uDecoder (
        .instr(ifIdInstr), .aluOp(decAluOp), .useImm(decUseImm), .immValue(decImm),
        .useShamt(decUseShamt), .destReg(decDest), .regWrite(decWrite),
        .branchKind(decBranch)
    );

    regFile uRegFile (
        .clk(clk), .rst(rst), .readAddrA(ifIdInstr[25:21]), .readAddrB(ifIdInstr[20:16]),
        .writeEn(wbWrite), .writeAddr(wbDest), .writeData(wbData),
        .readDataA(rfDataA), .readDataB(rfDataB)
    );

    bypassUnit uBypass (
        .srcA(ifIdInstr[25:21]), .srcB(ifIdInstr[20:16]), .exDest(idExDest),
        .exWrite(idExWrite), .wbDest(wbDest), .wbWrite(wbWrite), .fwdA(fwdA), .fwdB(fwdB)
    );

    assign opA = pickOperand(fwdA, rfDataA, exResult, wbData);
    assign opB = pickOperand(fwdB, rfDataB, exResult, wbData);

    // ID/EX
    always_ff @(posedge clk) begin
        if (rst) begin
            idExWrite <= 1'b0;
        end else begin
            idExWrite <= decWrite;
        end
    end

    always_ff @(posedge clk) begin
        idExPc       <= ifIdPc;
        idExA        <= opA;
        idExB        <= decUseImm ? decImm : opB;
        idExAluOp    <= decAluOp;
        idExShamt    <= ifIdInstr[10:6];
        idExUseShamt <= decUseShamt;
        idExDest     <= decDest;
    end

    alu uAlu (
        .aluOp(idExAluOp), .operandA(idExA), .operandB(idExB), .shamt(idExShamt),
        .useShamt(idExUseShamt), .result(exResult)
    );

    // EX/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            wbWrite <= 1'b0;
        end else begin
            wbWrite <= idExWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbPc   <= idExPc;
        wbData <= exResult;
        wbDest <= idExDest;
    end

    assign debugWbPc      = wbPc;
    assign debugWbRfWen   = {4{wbWrite}};
    assign debugWbRfWnum  = wbDest;
    assign debugWbRfWdata = wbData;

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import coreDefs::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT readAddrA,
    input  regAddrT readAddrB,
    input  logic    writeEn,
    input  regAddrT writeAddr,
    input  wordT    writeData,
    output wordT    readDataA,
    output wordT    readDataB
);

    wordT regs [1:31];  // r0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= 31; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // no write-through here, the bypass handles the writeback case
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

/* verification/coreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module coreTb import coreDefs::*; ();

    localparam int resetCycles = 8;
    localparam int drainCycles = 4;
    localparam int slackCycles = 20;

    logic clk;
    logic rst;
    wordT instData;
    wordT instAddr;
    wordT debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddrT debugWbRfWnum;
    wordT debugWbRfWdata;

    wordT imem [0:63];
    wordT fetchAddr;
    wordT prog[$];
    wordT expPc[$];
    wordT expData[$];
    regAddrT expNum[$];
    wordT gotPc[$];
    wordT gotData[$];
    regAddrT gotNum[$];
    int gotCycle[$];
    int cycleCount = 0;
    int cycleLimit = resetCycles + 2;
    int releaseCycle;
    int valueErrors = 0;
    int eventErrors = 0;
    logic [31:0] lcgState = 32'd64;

    mipsCore dut (
        .clk(clk), .rst(rst), .instData(instData), .instAddr(instAddr),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic wordT memWord(wordT addr);
        wordT offset;
        offset = addr - resetPc;
        if (offset[1:0] == 2'b00 && offset < 32'd256) return imem[offset[7:2]];
        return '0;  // nop outside the program
    endfunction

    function automatic wordT rType(regAddrT rs, regAddrT rt, regAddrT rd, logic [4:0] sa,
                                   logic [5:0] fn);
        return {opSpecial, rs, rt, rd, sa, fn};
    endfunction

    function automatic wordT iType(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // sync read memory sampling the address at negedge
    always @(negedge clk) fetchAddr = instAddr;
    always @(posedge clk) begin
        #2 instData = memWord(fetchAddr);
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: register writes still missing after %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            checkWord("instAddr", instAddr, resetPc);
            checkEnable("debugWbRfWen", debugWbRfWen, 4'h0);
        end else if (debugWbRfWen !== 4'h0) begin
            checkEnable("debugWbRfWen", debugWbRfWen, 4'hF);
            gotPc.push_back(debugWbPc);
            gotNum.push_back(debugWbRfWnum);
            gotData.push_back(debugWbRfWdata);
            gotCycle.push_back(cycleCount);
        end
    end

    task automatic checkWord(string sig, wordT got, wordT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic checkReg(string sig, regAddrT got, regAddrT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, sig, got, exp);
        end
    endtask

    task automatic checkEnable(string sig, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, sig, got, exp);
        end
    endtask

    // program order ISA model with delay slots
    task automatic modelRun();
        wordT regs [0:31];
        wordT pc;
        wordT npc;
        wordT nnpc;
        wordT instr;
        wordT a;
        wordT b;
        wordT res;
        wordT sImm;
        wordT zImm;
        regAddrT rd;
        logic wr;
        int steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        pc = resetPc;
        npc = resetPc + 32'd4;
        steps = 0;
        while (steps < 200 && pc >= resetPc && pc < resetPc + 32'(4 * prog.size())) begin
            instr = prog[(pc - resetPc) >> 2];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            sImm = {{16{instr[15]}}, instr[15:0]};
            zImm = {16'h0000, instr[15:0]};
            nnpc = npc + 32'd4;
            rd = instr[20:16];
            wr = 1'b1;
            res = '0;
            case (instr[31:26])
                opSpecial: begin
                    rd = instr[15:11];
                    case (instr[5:0])
                        fnSll:  res = b << instr[10:6];
                        fnSrl:  res = b >> instr[10:6];
                        fnSra:  res = wordT'($signed(b) >>> instr[10:6]);
                        fnAddu: res = a + b;
                        fnSubu: res = a - b;
                        fnAnd:  res = a & b;
                        fnOr:   res = a | b;
                        fnXor:  res = a ^ b;
                        fnNor:  res = ~(a | b);
                        fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSltu: res = (a < b) ? 32'd1 : 32'd0;
                        fnJr: begin
                            wr = 1'b0;
                            nnpc = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                opJ: begin
                    wr = 1'b0;
                    nnpc = {npc[31:28], instr[25:0], 2'b00};
                end
                opBeq: begin
                    wr = 1'b0;
                    if (a == b) nnpc = npc + (sImm << 2);
                end
                opBne: begin
                    wr = 1'b0;
                    if (a != b) nnpc = npc + (sImm << 2);
                end
                opAddiu: res = a + sImm;
                opSlti:  res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                opSltiu: res = (a < sImm) ? 32'd1 : 32'd0;
                opAndi:  res = a & zImm;
                opOri:   res = a | zImm;
                opXori:  res = a ^ zImm;
                opLui:   res = {instr[15:0], 16'h0000};
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                regs[rd] = res;
                expPc.push_back(pc);
                expNum.push_back(rd);
                expData.push_back(res);
            end
            pc = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic runProgram(string name);
        expPc.delete();
        expNum.delete();
        expData.delete();
        modelRun();
        for (int i = 0; i < 64; i++) imem[i] = (i < prog.size()) ? prog[i] : '0;
        cycleLimit += prog.size() + slackCycles + resetCycles + drainCycles + 2;
        @(posedge clk);
        #2 rst = 1'b1;
        gotPc.delete();
        gotNum.delete();
        gotData.delete();
        gotCycle.delete();
        repeat (resetCycles) @(posedge clk);
        #2 rst = 1'b0;
        releaseCycle = cycleCount;
        while (gotPc.size() < expPc.size()) @(posedge clk);
        repeat (drainCycles) @(posedge clk);  // window for extra writes
        for (int i = 0; i < expPc.size() && i < gotPc.size(); i++) begin
            checkWord("debugWbPc", gotPc[i], expPc[i]);
            checkReg("debugWbRfWnum", gotNum[i], expNum[i]);
            checkWord("debugWbRfWdata", gotData[i], expData[i]);
        end
        if (gotPc.size() != expPc.size()) begin
            eventErrors++;
            $display("%s: DUT made %0d register writes where %0d were expected",
                     name, gotPc.size(), expPc.size());
        end
    endtask

    task automatic loadConst(regAddrT r, wordT value);
        prog.push_back(iType(opLui, 5'd0, r, value[31:16]));
        prog.push_back(iType(opOri, r, r, value[15:0]));
    endtask

    task automatic resetTimingTest();
        prog.delete();
        prog.push_back(iType(opAddiu, 5'd0, 5'd1, 16'h1234));
        prog.push_back(iType(opAddiu, 5'd1, 5'd2, 16'hFFFF));
        runProgram("reset");
        if (gotCycle.size() > 0 && gotCycle[0] != releaseCycle + 3) begin
            eventErrors++;
            $display("first write came %0d cycles after reset instead of 3",
                     gotCycle[0] - releaseCycle);
        end
    endtask

    task automatic aluOpsTest();
        wordT x;
        wordT y;
        logic [15:0] imm;
        x = lcgNext();
        y = lcgNext() | 32'h8000_0000;  // negative for sra
        imm = 16'(lcgNext()) | 16'h8000;  // sign bit set
        prog.delete();
        loadConst(5'd1, x);
        loadConst(5'd2, y);
        prog.push_back(rType(5'd1, 5'd2, 5'd3, 5'd0, fnAddu));
        prog.push_back(rType(5'd1, 5'd2, 5'd4, 5'd0, fnSubu));
        prog.push_back(rType(5'd1, 5'd2, 5'd5, 5'd0, fnAnd));
        prog.push_back(rType(5'd1, 5'd2, 5'd6, 5'd0, fnOr));
        prog.push_back(rType(5'd1, 5'd2, 5'd7, 5'd0, fnXor));
        prog.push_back(rType(5'd1, 5'd2, 5'd8, 5'd0, fnNor));
        prog.push_back(rType(5'd1, 5'd2, 5'd9, 5'd0, fnSlt));
        prog.push_back(rType(5'd1, 5'd2, 5'd10, 5'd0, fnSltu));
        prog.push_back(rType(5'd0, 5'd2, 5'd11, 5'(lcgNext()), fnSll));
        prog.push_back(rType(5'd0, 5'd2, 5'd12, 5'(lcgNext()), fnSrl));
        prog.push_back(rType(5'd0, 5'd2, 5'd13, 5'(lcgNext()), fnSra));
        prog.push_back(iType(opAddiu, 5'd1, 5'd14, imm));
        prog.push_back(iType(opSlti, 5'd1, 5'd15, imm));
        prog.push_back(iType(opSltiu, 5'd1, 5'd16, imm));
        prog.push_back(iType(opAndi, 5'd1, 5'd17, imm));
        prog.push_back(iType(opOri, 5'd1, 5'd18, imm));
        prog.push_back(iType(opXori, 5'd1, 5'd19, imm));
        prog.push_back(iType(opLui, 5'd0, 5'd20, 16'(lcgNext())));
        runProgram("alu");
    endtask

    task automatic forwardTest();
        prog.delete();
        loadConst(5'd1, lcgNext());
        loadConst(5'd2, lcgNext());
        prog.push_back(rType(5'd1, 5'd2, 5'd3, 5'd0, fnAddu));
        prog.push_back(rType(5'd3, 5'd1, 5'd4, 5'd0, fnSubu));
        prog.push_back(rType(5'd4, 5'd3, 5'd5, 5'd0, fnXor));
        prog.push_back(rType(5'd5, 5'd5, 5'd6, 5'd0, fnOr));
        prog.push_back(rType(5'd6, 5'd4, 5'd7, 5'd0, fnAnd));   // two back
        prog.push_back(iType(opAddiu, 5'd7, 5'd8, 16'(lcgNext())));
        prog.push_back(rType(5'd8, 5'd6, 5'd9, 5'd0, fnSlt));
        prog.push_back(rType(5'd0, 5'd9, 5'd9, 5'd3, fnSll));
        runProgram("forward");
    endtask

    task automatic branchTest();
        wordT jrTarget;
        wordT jTarget;
        jrTarget = resetPc + 32'd64;
        jTarget = resetPc + 32'd44;
        prog.delete();
        prog.push_back(iType(opAddiu, 5'd0, 5'd1, 16'd5));
        prog.push_back(iType(opAddiu, 5'd0, 5'd2, 16'd5));
        prog.push_back(iType(opBeq, 5'd1, 5'd2, 16'd2));    // taken to word 5
        prog.push_back(iType(opAddiu, 5'd0, 5'd3, 16'd1));
        prog.push_back(iType(opAddiu, 5'd0, 5'd4, 16'd2));  // skipped
        prog.push_back(iType(opBne, 5'd1, 5'd2, 16'd2));    // not taken
        prog.push_back(iType(opAddiu, 5'd0, 5'd5, 16'd3));
        prog.push_back(iType(opAddiu, 5'd0, 5'd6, 16'd4));
        prog.push_back({opJ, jTarget[27:2]});
        prog.push_back(iType(opAddiu, 5'd0, 5'd7, 16'd6));
        prog.push_back(iType(opAddiu, 5'd0, 5'd8, 16'd7));  // skipped
        loadConst(5'd10, jrTarget);
        prog.push_back(rType(5'd10, 5'd0, 5'd0, 5'd0, fnJr));
        prog.push_back(iType(opAddiu, 5'd0, 5'd11, 16'd8));
        prog.push_back(iType(opAddiu, 5'd0, 5'd12, 16'd9)); // skipped
        prog.push_back(iType(opAddiu, 5'd0, 5'd13, 16'd10));
        prog.push_back(iType(opBne, 5'd1, 5'd3, 16'd2));    // taken to word 20
        prog.push_back(iType(opAddiu, 5'd0, 5'd14, 16'd11));
        prog.push_back(iType(opAddiu, 5'd0, 5'd15, 16'd12)); // skipped
        prog.push_back(iType(opBeq, 5'd1, 5'd3, 16'd2));    // not taken
        prog.push_back(iType(opAddiu, 5'd0, 5'd16, 16'd13));
        prog.push_back(iType(opAddiu, 5'd0, 5'd17, 16'd14));
        runProgram("branch");
    endtask

    task automatic ignoredWriteTest();
        prog.delete();
        prog.push_back(iType(opAddiu, 5'd0, 5'd0, 16'h0055));
        prog.push_back(iType(6'h3F, 5'd0, 5'd5, 16'h1111));          // unknown opcode
        prog.push_back(rType(5'd0, 5'd0, 5'd6, 5'd0, 6'h3F));         // unknown funct
        prog.push_back(rType(5'd0, 5'd0, 5'd7, 5'd0, fnAddu));        // reads r0
        prog.push_back(iType(opOri, 5'd0, 5'd8, 16'h0001));
        runProgram("ignored");
    endtask

    initial begin
        rst = 1'b1;
        instData = '0;
        fetchAddr = resetPc;
        for (int i = 0; i < 64; i++) imem[i] = '0;
        resetTimingTest();
        aluOpsTest();
        forwardTest();
        branchTest();
        ignoredWriteTest();
        $display("errors: %0d value, %0d event", valueErrors, eventErrors);
        if (valueErrors == 0 && eventErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
